//--- hw/soc_bus_pkg.sv
package soc_bus_pkg;

    // --------------------------------------------------
    // Bus payload types
    // --------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;                // One bit per byte lane

    // --------------------------------------------------
    // Memory map
    // --------------------------------------------------
    localparam addr_t RAM_BASE  = 32'hFFFF_0000; // Internal RAM in the top 64 KB
    localparam int    RAM_WORDS = 2048;          // 8 KB deep
    localparam int    RAM_AW    = 11;            // Word index from addr[12:2]

    localparam addr_t GPIO_BASE = 32'h0300_0000;
    localparam addr_t GPIO_SPAN = 32'd256;
    localparam addr_t UART_ADDR = 32'h0300_0100; // Single mapped word

    // GPIO register indices from addr[5:2]
    localparam int GPIO_IDX_W = 4;
    localparam logic [GPIO_IDX_W-1:0] GPIO_LED_GREEN = 4'd1;
    localparam logic [GPIO_IDX_W-1:0] GPIO_LED_RED   = 4'd2;
    localparam logic [GPIO_IDX_W-1:0] GPIO_Z80_RST   = 4'd3;
    localparam logic [GPIO_IDX_W-1:0] GPIO_I2C_SCL   = 4'd5;
    localparam logic [GPIO_IDX_W-1:0] GPIO_I2C_SDA   = 4'd6;
    localparam logic [GPIO_IDX_W-1:0] GPIO_USB_RST   = 4'd7;

    // Returned when nothing answers the address
    localparam data_t UNMAPPED_DATA = 32'hFFFF_FFFF;

    // --------------------------------------------------
    // UART timing
    // --------------------------------------------------
    localparam int CLKS_PER_BIT    = 16;
    localparam int UART_FRAME_BITS = 10;        // Start, 8 data, stop

endpackage

//--- hw/periph_if.sv
`timescale 1ns/1ps

// One decoded region of the host memory bus
interface periph_if;
    import soc_bus_pkg::*;

    logic  valid;   // Request already gated by the region select
    addr_t addr;
    data_t wdata;
    strb_t wstrb;   // Zero means read
    data_t rdata;
    logic  ready;

    // Decoder side
    modport host (
        output valid,
        output addr,
        output wdata,
        output wstrb,
        input  rdata,
        input  ready
    );

    // Peripheral side
    modport dev (
        input  valid,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata,
        output ready
    );

endinterface

//--- hw/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic                clk_rv,
    input  logic                rst_rv,
    input  logic                mem_valid,
    input  soc_bus_pkg::addr_t  mem_addr,
    input  soc_bus_pkg::addr_t  mem_la_addr,
    input  soc_bus_pkg::data_t  mem_wdata,
    input  soc_bus_pkg::strb_t  mem_wstrb,
    output logic                mem_ready,
    output soc_bus_pkg::data_t  mem_rdata,
    output logic                irq,
    periph_if.host              ram,
    periph_if.host              gpio,
    periph_if.host              uart
);
    import soc_bus_pkg::*;

    logic la_in_ram;
    logic la_in_gpio;
    logic la_in_uart;

    logic sel_ram;
    logic sel_gpio;
    logic sel_uart;
    logic sel_none;         // Access hits no region

    logic none_ready;
    logic mem_valid_q;

    // --------------------------------------------------
    // Region select from the look-ahead address
    // --------------------------------------------------
    assign la_in_ram  = (mem_la_addr >= RAM_BASE);
    assign la_in_gpio = (mem_la_addr >= GPIO_BASE) &&
                        (mem_la_addr < (GPIO_BASE + GPIO_SPAN));
    assign la_in_uart = (mem_la_addr == UART_ADDR);

    // Flags settle one cycle ahead of mem_valid
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            sel_ram  <= 1'b0;
            sel_gpio <= 1'b0;
            sel_uart <= 1'b0;
            sel_none <= 1'b0;
        end else begin
            sel_ram  <= la_in_ram;
            sel_gpio <= la_in_gpio;
            sel_uart <= la_in_uart;
            sel_none <= !(la_in_ram || la_in_gpio || la_in_uart);
        end
    end

    // --------------------------------------------------
    // Per-region request
    // --------------------------------------------------
    // RAM and GPIO answer in a fixed cycle, so drop valid once they are ready
    assign ram.valid  = mem_valid && sel_ram && !ram.ready;
    assign gpio.valid = mem_valid && sel_gpio && !gpio.ready;
    assign uart.valid = mem_valid && sel_uart;   // UART stretches its own ready

    assign ram.addr   = mem_addr;
    assign ram.wdata  = mem_wdata;
    assign ram.wstrb  = mem_wstrb;

    assign gpio.addr  = mem_addr;
    assign gpio.wdata = mem_wdata;
    assign gpio.wstrb = mem_wstrb;

    assign uart.addr  = mem_addr;
    assign uart.wdata = mem_wdata;
    assign uart.wstrb = mem_wstrb;

    // --------------------------------------------------
    // Unmapped access and bus-error interrupt
    // --------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            none_ready  <= 1'b0;
            mem_valid_q <= 1'b0;
            irq         <= 1'b0;
        end else begin
            none_ready  <= mem_valid && sel_none && !none_ready;
            mem_valid_q <= mem_valid;
            if (mem_valid && !mem_valid_q && sel_none) begin
                irq <= 1'b1;                    // Sticky until reset
            end
        end
    end

    // --------------------------------------------------
    // Merge back to the host
    // --------------------------------------------------
    assign mem_ready = ram.ready || gpio.ready || uart.ready || none_ready;

    always_comb begin
        if (sel_ram) begin
            mem_rdata = ram.rdata;
        end else if (sel_gpio) begin
            mem_rdata = gpio.rdata;
        end else if (sel_uart) begin
            mem_rdata = uart.rdata;
        end else begin
            mem_rdata = UNMAPPED_DATA;
        end
    end

endmodule

//--- hw/sram_word.sv
`timescale 1ns/1ps

module sram_word (
    input  logic    clk_rv,
    periph_if.dev   bus
);
    import soc_bus_pkg::*;

    data_t             mem [RAM_WORDS];
    logic [RAM_AW-1:0] word_idx;

    // Upper address bits ignored, so the 8 KB repeats over the window
    assign word_idx = bus.addr[RAM_AW+1:2];

    // --------------------------------------------------
    // Array with byte lanes
    // --------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (bus.valid) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.wstrb[i]) begin
                    mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
            bus.rdata <= mem[word_idx];     // Old word on a write
        end
    end

    // Ready follows valid by one cycle
    always_ff @(posedge clk_rv) begin
        bus.ready <= bus.valid;
    end

endmodule

//--- hw/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
    input  logic    clk_rv,
    input  logic    rst_rv,
    periph_if.dev   bus,
    input  logic    i2c_sda_in,
    output logic    led_red_n,
    output logic    led_green_n,
    output logic    z80_rst,
    output logic    i2c_scl,
    output logic    i2c_sda_low,
    output logic    usb_rst_n
);
    import soc_bus_pkg::*;

    logic [GPIO_IDX_W-1:0] reg_idx;
    logic                  wr_en;

    logic led_green_q;
    logic led_red_q;
    logic z80_rst_q;
    logic scl_q;
    logic sda_q;
    logic usb_rst_q;

    assign reg_idx = bus.addr[GPIO_IDX_W+1:2];
    assign wr_en   = bus.valid && (bus.wstrb != '0);

    // --------------------------------------------------
    // Register bank with one bit per index
    // --------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            led_green_q <= 1'b0;
            led_red_q   <= 1'b0;
            z80_rst_q   <= 1'b1;            // Hold the Z80 in reset
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;            // Released
            usb_rst_q   <= 1'b0;
            bus.ready   <= 1'b0;
        end else begin
            bus.ready <= bus.valid;
            if (wr_en) begin
                case (reg_idx)
                    GPIO_LED_GREEN: led_green_q <= bus.wdata[0];
                    GPIO_LED_RED:   led_red_q   <= bus.wdata[0];
                    GPIO_Z80_RST:   z80_rst_q   <= bus.wdata[0];
                    GPIO_I2C_SCL:   scl_q       <= bus.wdata[0];
                    GPIO_I2C_SDA:   sda_q       <= bus.wdata[0];
                    GPIO_USB_RST:   usb_rst_q   <= bus.wdata[0];
                    default: ;                  // Unused slots ignore writes
                endcase
            end
        end
    end

    // Only two indices read back anything
    always_ff @(posedge clk_rv) begin
        if (bus.valid) begin
            case (reg_idx)
                GPIO_Z80_RST: bus.rdata <= {31'd0, z80_rst_q};
                GPIO_I2C_SDA: bus.rdata <= {31'd0, i2c_sda_in};
                default:      bus.rdata <= '0;
            endcase
        end
    end

    // --------------------------------------------------
    // Pin drive
    // --------------------------------------------------
    assign led_green_n = !led_green_q;      // LEDs are active low
    assign led_red_n   = !led_red_q;
    assign z80_rst     = z80_rst_q;
    assign i2c_scl     = scl_q;
    assign i2c_sda_low = !sda_q;            // Open drain pulls low on 0
    assign usb_rst_n   = usb_rst_q;

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic    clk_rv,
    input  logic    rst_rv,
    periph_if.dev   bus,
    output logic    txd
);
    import soc_bus_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(UART_FRAME_BITS);
    localparam logic [CNT_W-1:0] CLK_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(UART_FRAME_BITS - 1);

    logic                       busy;
    logic                       accept;
    logic [UART_FRAME_BITS-1:0] shreg;      // Frame sent from bit 0
    logic [CNT_W-1:0]           clk_cnt;
    logic [BIT_W-1:0]           bit_cnt;

    // Ready only when no frame is on the line
    assign accept    = bus.valid && !busy;
    assign bus.ready = accept;
    assign bus.rdata = '0;

    // --------------------------------------------------
    // Frame shifter
    // --------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            busy    <= 1'b0;
            shreg   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (accept && (bus.wstrb != '0)) begin
            busy    <= 1'b1;
            shreg   <= {1'b1, bus.wdata[7:0], 1'b0};   // Stop, data, start
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (clk_cnt == CLK_LAST) begin
                clk_cnt <= '0;
                shreg   <= {1'b1, shreg[UART_FRAME_BITS-1:1]};
                if (bit_cnt == BIT_LAST) begin
                    busy <= 1'b0;               // Stop bit done
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    assign txd = busy ? shreg[0] : 1'b1;    // Line idles high

endmodule

//--- hw/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                clk_rv,
    input  logic                rst_rv,
    // Host memory bus
    input  logic                mem_valid,
    input  soc_bus_pkg::addr_t  mem_addr,
    input  soc_bus_pkg::addr_t  mem_la_addr,
    input  soc_bus_pkg::data_t  mem_wdata,
    input  soc_bus_pkg::strb_t  mem_wstrb,
    output logic                mem_ready,
    output soc_bus_pkg::data_t  mem_rdata,
    output logic                irq,
    // Board pins
    input  logic                i2c_sda_in,
    output logic                txd,
    output logic                led_red_n,
    output logic                led_green_n,
    output logic                z80_rst,
    output logic                i2c_scl,
    output logic                i2c_sda_low,
    output logic                usb_rst_n
);

    periph_if ram_bus ();
    periph_if gpio_bus ();
    periph_if uart_bus ();

    bus_decoder u_bus_decoder (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .mem_la_addr (mem_la_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .irq         (irq),
        .ram         (ram_bus),
        .gpio        (gpio_bus),
        .uart        (uart_bus)
    );

    sram_word u_sram_word (
        .clk_rv (clk_rv),
        .bus    (ram_bus)
    );

    gpio_regs u_gpio_regs (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .bus         (gpio_bus),
        .i2c_sda_in  (i2c_sda_in),
        .led_red_n   (led_red_n),
        .led_green_n (led_green_n),
        .z80_rst     (z80_rst),
        .i2c_scl     (i2c_scl),
        .i2c_sda_low (i2c_sda_low),
        .usb_rst_n   (usb_rst_n)
    );

    uart_tx u_uart_tx (
        .clk_rv (clk_rv),
        .rst_rv (rst_rv),
        .bus    (uart_bus),
        .txd    (txd)       // Serial line idles high
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_rv,
    output logic rst_rv
);
    localparam int HALF_PERIOD  = 4;    // 8 ns period
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_rv = 1'b0;
        forever #HALF_PERIOD clk_rv = !clk_rv;
    end

    initial begin
        rst_rv = 1'b0;                  // Active low from time zero
        repeat (RESET_CYCLES) @(posedge clk_rv);
        rst_rv <= 1'b1;
    end

endmodule

//--- testbench/soc_bus_checker.sv
`timescale 1ns/1ps

module soc_bus_checker (
    input  logic                clk_rv,
    input  logic                rst_rv,
    input  logic                mem_valid,
    input  soc_bus_pkg::addr_t  mem_addr,
    input  soc_bus_pkg::strb_t  mem_wstrb,
    input  logic                mem_ready,
    input  logic                irq,
    input  logic                txd
);
    import soc_bus_pkg::*;

    localparam int FRAME_CLKS = CLKS_PER_BIT * UART_FRAME_BITS;

    int   fail_cnt = 0;
    int   frame_left;       // Cycles of the current UART frame still to go
    logic uart_hit;
    logic unmapped;

    assign uart_hit = (mem_addr == UART_ADDR);
    assign unmapped = !((mem_addr >= RAM_BASE) || uart_hit ||
                        ((mem_addr >= GPIO_BASE) && (mem_addr < GPIO_BASE + GPIO_SPAN)));

    function automatic void count_failure(input string what);
        fail_cnt++;
        $error("%s", what);
    endfunction

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            frame_left <= 0;
        end else if (mem_valid && mem_ready && uart_hit && (mem_wstrb != '0)) begin
            frame_left <= FRAME_CLKS;       // Frame starts next cycle
        end else if (frame_left != 0) begin
            frame_left <= frame_left - 1;
        end
    end

    // --------------------------------------------------
    // Reset state and handshake
    // --------------------------------------------------
    reset_idle: assert property (@(posedge clk_rv)
        !rst_rv |=> (!mem_ready && !irq && txd))
        else count_failure("Bus outputs not idle after reset");

    ready_needs_valid: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        mem_ready |-> mem_valid)
        else count_failure("mem_ready high without mem_valid");

    fixed_latency: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        ($rose(mem_valid) && !uart_hit) |-> !mem_ready ##1 mem_ready)
        else count_failure("RAM, GPIO or unmapped access missed one-cycle ready");

    // --------------------------------------------------
    // Interrupt and UART framing
    // --------------------------------------------------
    irq_on_unmapped: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        ($rose(mem_valid) && unmapped) |=> irq)
        else count_failure("irq did not rise after an unmapped access");

    irq_sticky: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        irq |=> irq)
        else count_failure("irq dropped before reset");

    uart_hold_off: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        (frame_left != 0) |-> !(mem_ready && uart_hit))
        else count_failure("UART gave ready while a frame was on the line");

    uart_start_bit: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        (frame_left == FRAME_CLKS) |-> !txd)
        else count_failure("UART frame did not begin with a low start bit");

    uart_line_high: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        (frame_left <= 1) |-> txd)  // Last stop cycle and idle
        else count_failure("txd low outside a frame or during the stop bit");

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import soc_bus_pkg::*;

    // The run is about four UART frames long, so this leaves ample room
    localparam int    TIMEOUT_CYCLES = 25 * CLKS_PER_BIT * UART_FRAME_BITS;
    localparam strb_t PART_STRB      = 4'b0101;

    logic  clk_rv;
    logic  rst_rv;
    logic  mem_valid;
    addr_t mem_addr;
    addr_t mem_la_addr;
    data_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_ready;
    data_t mem_rdata;
    logic  irq;
    logic  i2c_sda_in;
    logic  txd;
    logic  led_red_n;
    logic  led_green_n;
    logic  z80_rst;
    logic  i2c_scl;
    logic  i2c_sda_low;
    logic  usb_rst_n;

    int         errors = 0;
    int         cycles = 0;
    int         seed;
    int         waits;          // Cycles of valid before ready in the last access
    data_t      rd;
    data_t      words [4];
    data_t      new_word;
    data_t      exp_word;
    logic [7:0] tx_byte;

    tb_clock_gen u_clock_gen (.clk_rv(clk_rv), .rst_rv(rst_rv));

    soc_bus_top u_soc_bus_top (.*);

    bind soc_bus_top soc_bus_checker u_soc_bus_checker (.*);

    function automatic void check_value(input string name, input data_t exp, input data_t act);
        assert (act === exp) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endfunction

    function automatic addr_t gpio_addr(input logic [GPIO_IDX_W-1:0] idx);
        return GPIO_BASE + {26'd0, idx, 2'b00};
    endfunction

    // --------------------------------------------------
    // Host bus tasks
    // --------------------------------------------------
    task automatic do_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                             output data_t rdata, output int wait_cnt);
        @(posedge clk_rv);
        mem_la_addr <= addr;                // One cycle ahead of valid
        @(posedge clk_rv);
        mem_addr  <= addr;
        mem_wdata <= wdata;
        mem_wstrb <= wstrb;
        mem_valid <= 1'b1;
        wait_cnt = 0;
        @(posedge clk_rv);
        while (!mem_ready) begin
            wait_cnt++;
            @(posedge clk_rv);
        end
        rdata = mem_rdata;
        mem_valid <= 1'b0;
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t wstrb);
        do_access(addr, wdata, wstrb, rd, waits);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        do_access(addr, '0, '0, rdata, waits);
    endtask

    // Samples each bit in its middle, starting from the falling start edge
    task automatic sample_frame(input string name, input logic [7:0] data);
        logic exp_bit;
        do @(posedge clk_rv); while (txd);
        repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk_rv);
        for (int i = 0; i < UART_FRAME_BITS; i++) begin
            if (i == 0) begin
                exp_bit = 1'b0;
            end else if (i == UART_FRAME_BITS - 1) begin
                exp_bit = 1'b1;
            end else begin
                exp_bit = data[i-1];        // LSB first
            end
            check_value($sformatf("%s bit %0d", name, i), data_t'(exp_bit), data_t'(txd));
            repeat (CLKS_PER_BIT) @(posedge clk_rv);
        end
    endtask

    always @(posedge clk_rv) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        mem_valid   = 1'b0;
        mem_addr    = '0;
        mem_la_addr = '0;
        mem_wdata   = '0;
        mem_wstrb   = '0;
        i2c_sda_in  = 1'b1;
        seed        = 32'h65a4;
        do @(posedge clk_rv); while (!rst_rv);
        // ready, irq, txd, red, green, z80, scl, sda_low, usb_rst_n
        check_value("reset state", 32'b0_0111_1100,
                    data_t'({mem_ready, irq, txd, led_red_n, led_green_n, z80_rst,
                             i2c_scl, i2c_sda_low, usb_rst_n}));

        // --------------------------------------------------
        // RAM
        // --------------------------------------------------
        for (int i = 0; i < 4; i++) begin
            words[i] = $random(seed);
            bus_write(RAM_BASE + i * 16, words[i], 4'hF);
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(RAM_BASE + i * 16, rd);
            check_value("ram readback", words[i], rd);
        end
        new_word = $random(seed);
        bus_write(RAM_BASE, new_word, PART_STRB);
        for (int b = 0; b < 4; b++) begin
            exp_word[8*b +: 8] = PART_STRB[b] ? new_word[8*b +: 8] : words[0][8*b +: 8];
        end
        bus_read(RAM_BASE, rd);
        check_value("ram partial strobe", exp_word, rd);
        bus_read(RAM_BASE + 32'h2000, rd);  // 8 KB higher hits the same cell
        check_value("ram echo", exp_word, rd);

        // --------------------------------------------------
        // GPIO
        // --------------------------------------------------
        bus_write(gpio_addr(GPIO_LED_GREEN), 32'd1, 4'hF);
        bus_write(gpio_addr(GPIO_LED_RED), 32'd1, 4'hF);
        bus_write(gpio_addr(GPIO_I2C_SCL), 32'd0, 4'hF);
        bus_write(gpio_addr(GPIO_I2C_SDA), 32'd0, 4'hF);
        bus_write(gpio_addr(GPIO_USB_RST), 32'd1, 4'hF);
        bus_write(gpio_addr(GPIO_Z80_RST), 32'd0, 4'hF);
        // green_n, red_n, scl, sda_low, usb_rst_n, z80_rst
        check_value("gpio pins", 32'b00_0110, data_t'({led_green_n, led_red_n, i2c_scl,
                                                        i2c_sda_low, usb_rst_n, z80_rst}));
        bus_read(gpio_addr(GPIO_Z80_RST), rd);
        check_value("gpio z80 low", 32'd0, rd);
        bus_write(gpio_addr(GPIO_Z80_RST), 32'd1, 4'hF);
        bus_read(gpio_addr(GPIO_Z80_RST), rd);
        check_value("gpio z80 high", 32'd1, rd);
        bus_write(gpio_addr(GPIO_I2C_SDA), 32'd1, 4'hF);
        check_value("gpio sda released", 32'd0, data_t'(i2c_sda_low));
        i2c_sda_in <= 1'b0;
        bus_read(gpio_addr(GPIO_I2C_SDA), rd);
        check_value("gpio sda in low", 32'd0, rd);
        i2c_sda_in <= 1'b1;
        bus_read(gpio_addr(GPIO_I2C_SDA), rd);
        check_value("gpio sda in high", 32'd1, rd);
        bus_read(gpio_addr(4'd0), rd);
        check_value("gpio unused index", 32'd0, rd);

        // --------------------------------------------------
        // Unmapped access and irq
        // --------------------------------------------------
        bus_read(32'h1000_0000, rd);
        check_value("unmapped data", UNMAPPED_DATA, rd);
        check_value("unmapped latency", 32'd1, data_t'(waits));
        check_value("irq raised", 32'd1, data_t'(irq));
        bus_read(RAM_BASE, rd);
        check_value("irq held", 32'd1, data_t'(irq));

        // --------------------------------------------------
        // UART
        // --------------------------------------------------
        tx_byte = 8'($random(seed));
        bus_write(UART_ADDR, {24'd0, tx_byte}, 4'h1);
        sample_frame("uart frame a", tx_byte);
        bus_read(UART_ADDR, rd);
        check_value("uart read", 32'd0, rd);
        bus_write(UART_ADDR, 32'h0000_00C3, 4'h1);
        bus_write(UART_ADDR, 32'h0000_003C, 4'h1);
        // Second valid rises two cycles into the first frame
        check_value("uart hold off", data_t'(CLKS_PER_BIT * UART_FRAME_BITS - 2),
                    data_t'(waits));
        sample_frame("uart frame c", 8'h3C);

        repeat (2) @(posedge clk_rv);
        $display("Errors: %0d in testbench checks, %0d in checker assertions",
                 errors, u_soc_bus_top.u_soc_bus_checker.fail_cnt);
        if (errors == 0 && u_soc_bus_top.u_soc_bus_checker.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/soc_bus_pkg.sv
hw/periph_if.sv
hw/bus_decoder.sv
hw/sram_word.sv
hw/gpio_regs.sv
hw/uart_tx.sv
hw/soc_bus_top.sv
testbench/tb_clock_gen.sv
testbench/soc_bus_checker.sv
testbench/tb_top.sv

//--- Makefile
TOP := tb_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

# The error limit keeps assertion failures from ending the run before the summary
sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
